/* hdl/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// integer datapath width
`define XLEN 64

// 32 architectural registers
`define REG_ADDR_WIDTH 5

// data RAM holds 2**10 doublewords
`define DMEM_DEPTH_LOG2 10

// PC value seen in writeback before the first instruction retires
`define RESET_PC 64'h8000_0000

`endif

/* hdl/rv_core_pkg.sv */
`default_nettype none

`include "core_defines.svh"

package rv_core_pkg;

	typedef logic [`XLEN-1:0]           xlen_t;      // one integer register
	typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;  // register index

	// memory operation carried by an instruction
	typedef enum logic [1:0] {
		MEM_NONE  = 2'd0,
		MEM_LOAD  = 2'd1,
		MEM_STORE = 2'd2
	} mem_op_e;

	// access size, encoded as log2 of the byte count
	typedef enum logic [1:0] {
		SZ_B = 2'd0,
		SZ_H = 2'd1,
		SZ_W = 2'd2,
		SZ_D = 2'd3
	} mem_size_e;

endpackage

`default_nettype wire

/* hdl/dmem_bus_pkg.sv */
`default_nettype none

`include "core_defines.svh"

package dmem_bus_pkg;

	typedef logic [`DMEM_DEPTH_LOG2-1:0] dmem_addr_t;  // doubleword index
	typedef logic [7:0]                  byte_mask_t;  // one bit per byte lane

	// who got the RAM port most recently
	typedef enum logic {
		OWN_CORE = 1'b0,
		OWN_HOST = 1'b1
	} arb_owner_e;

endpackage

`default_nettype wire

/* hdl/dmem_arbiter.sv */
`default_nettype none

module dmem_arbiter import rv_core_pkg::*, dmem_bus_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        core_req_i,
	input  wire        core_we_i,
	input  dmem_addr_t core_addr_i,
	input  byte_mask_t core_wmask_i,
	input  xlen_t      core_wdata_i,
	input  wire        host_req_i,
	input  wire        host_we_i,
	input  dmem_addr_t host_addr_i,
	input  byte_mask_t host_wmask_i,
	input  xlen_t      host_wdata_i,
	output logic       core_gnt_o,
	output logic       host_gnt_o,
	output logic       ram_en_o,
	output logic       ram_we_o,
	output dmem_addr_t ram_addr_o,
	output byte_mask_t ram_wmask_o,
	output xlen_t      ram_wdata_o
);

	arb_owner_e last_q;  // owner of the most recent grant
	arb_owner_e owner;   // owner this cycle

	// conflict goes to whoever did not win last time
	always_comb begin
		if (core_req_i && host_req_i)
			owner = (last_q == OWN_HOST) ? OWN_CORE : OWN_HOST;
		else if (host_req_i)
			owner = OWN_HOST;
		else
			owner = OWN_CORE;
	end

	assign core_gnt_o = core_req_i && (owner == OWN_CORE);
	assign host_gnt_o = host_req_i && (owner == OWN_HOST);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			last_q <= OWN_HOST;  // core wins the first conflict
		else if (core_gnt_o)
			last_q <= OWN_CORE;
		else if (host_gnt_o)
			last_q <= OWN_HOST;
	end

	// single RAM port
	assign ram_en_o    = core_req_i || host_req_i;
	assign ram_we_o    = (owner == OWN_HOST) ? host_we_i    : core_we_i;
	assign ram_addr_o  = (owner == OWN_HOST) ? host_addr_i  : core_addr_i;
	assign ram_wmask_o = (owner == OWN_HOST) ? host_wmask_i : core_wmask_i;
	assign ram_wdata_o = (owner == OWN_HOST) ? host_wdata_i : core_wdata_i;

endmodule

`default_nettype wire

/* hdl/dmem_ram.sv */
`default_nettype none

`include "core_defines.svh"

module dmem_ram import rv_core_pkg::*, dmem_bus_pkg::*; (
	input  wire        clk,
	input  wire        en_i,
	input  wire        we_i,
	input  dmem_addr_t addr_i,
	input  byte_mask_t wmask_i,
	input  xlen_t      wdata_i,
	output xlen_t      rdata_o
);

	localparam int DEPTH = 1 << `DMEM_DEPTH_LOG2;

	xlen_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (en_i) begin
			if (we_i) begin
				for (int i = 0; i < 8; i++) begin
					if (wmask_i[i])
						mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];  // lane write
				end
			end
			rdata_o <= mem[addr_i];  // old data on a write cycle
		end
	end

endmodule

`default_nettype wire

/* hdl/mem_stage.sv */
`default_nettype none

`include "core_defines.svh"

module mem_stage import rv_core_pkg::*, dmem_bus_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        ex_valid_i,
	input  xlen_t      ex_pc_i,
	input  xlen_t      ex_alu_res_i,
	input  reg_addr_t  ex_rd_i,
	input  wire        ex_reg_wen_i,
	input  mem_op_e    ex_mem_op_i,
	input  mem_size_e  ex_mem_size_i,
	input  wire        ex_mem_signed_i,
	input  xlen_t      ex_store_data_i,
	input  wire        ex_ebreak_i,
	input  wire        core_gnt_i,
	output logic       core_req_o,
	output logic       core_we_o,
	output dmem_addr_t core_addr_o,
	output byte_mask_t core_wmask_o,
	output xlen_t      core_wdata_o,
	output logic       stall_o,
	output logic       wen_o,
	output reg_addr_t  rd_o,
	output xlen_t      alu_res_o,
	output logic       is_load_o,
	output mem_size_e  size_o,
	output logic       signed_o,
	output logic [2:0] offset_o,
	output logic       ebreak_o,
	output xlen_t      pc_o
);

	logic       mem_req;  // valid load or store in this slot
	logic [2:0] offset;
	byte_mask_t size_mask;

	assign mem_req = ex_valid_i && (ex_mem_op_i != MEM_NONE);
	assign offset  = ex_alu_res_i[2:0];

	// lanes covered before shifting to the offset
	always_comb begin
		case (ex_mem_size_i)
			SZ_B:    size_mask = 8'h01;
			SZ_H:    size_mask = 8'h03;
			SZ_W:    size_mask = 8'h0f;
			default: size_mask = 8'hff;
		endcase
	end

	// EX holds the slot while stalled, so the request stays up
	assign core_req_o   = mem_req;
	assign core_we_o    = (ex_mem_op_i == MEM_STORE);
	assign core_addr_o  = ex_alu_res_i[`DMEM_DEPTH_LOG2+2:3];
	assign core_wmask_o = size_mask << offset;
	assign core_wdata_o = ex_store_data_i << {offset, 3'b000};  // data into its lanes
	assign stall_o      = core_req_o && !core_gnt_i;

	// fields for the MEM/WB register
	assign wen_o     = ex_valid_i && ex_reg_wen_i;  // invalid slot writes nothing
	assign rd_o      = ex_rd_i;
	assign alu_res_o = ex_alu_res_i;
	assign is_load_o = ex_valid_i && (ex_mem_op_i == MEM_LOAD);
	assign size_o    = ex_mem_size_i;
	assign signed_o  = ex_mem_signed_i;
	assign offset_o  = offset;
	assign ebreak_o  = ex_valid_i && ex_ebreak_i;
	assign pc_o      = ex_pc_i;

endmodule

`default_nettype wire

/* hdl/mem_wb_regs.sv */
`default_nettype none

`include "core_defines.svh"

module mem_wb_regs import rv_core_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        stall_i,
	input  wire        wen_i,
	input  reg_addr_t  rd_i,
	input  xlen_t      alu_res_i,
	input  wire        is_load_i,
	input  mem_size_e  size_i,
	input  wire        signed_i,
	input  wire [2:0]  offset_i,
	input  wire        ebreak_i,
	input  xlen_t      pc_i,
	output logic       wen_o,
	output reg_addr_t  rd_o,
	output xlen_t      alu_res_o,
	output logic       is_load_o,
	output mem_size_e  size_o,
	output logic       signed_o,
	output logic [2:0] offset_o,
	output logic       ebreak_o,
	output xlen_t      pc_o
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wen_o     <= 1'b0;
			rd_o      <= '0;
			alu_res_o <= '0;
			is_load_o <= 1'b0;
			size_o    <= SZ_B;
			signed_o  <= 1'b0;
			offset_o  <= 3'd0;
			ebreak_o  <= 1'b0;
			pc_o      <= `RESET_PC;
		end else if (stall_i) begin
			// bubble, payload stays where it is
			wen_o    <= 1'b0;
			ebreak_o <= 1'b0;
		end else begin
			wen_o     <= wen_i;
			rd_o      <= rd_i;
			alu_res_o <= alu_res_i;
			is_load_o <= is_load_i;
			size_o    <= size_i;
			signed_o  <= signed_i;
			offset_o  <= offset_i;
			ebreak_o  <= ebreak_i;
			pc_o      <= pc_i;
		end
	end

endmodule

`default_nettype wire

/* hdl/wb_stage.sv */
`default_nettype none

module wb_stage import rv_core_pkg::*; (
	input  wire        wen_i,
	input  reg_addr_t  rd_i,
	input  xlen_t      alu_res_i,
	input  wire        is_load_i,
	input  mem_size_e  size_i,
	input  wire        signed_i,
	input  wire [2:0]  offset_i,
	input  xlen_t      ram_rdata_i,
	output logic       rf_we_o,
	output reg_addr_t  rf_waddr_o,
	output xlen_t      rf_wdata_o
);

	xlen_t lanes;     // addressed byte moved down to lane 0
	xlen_t load_val;  // extended load result

	assign lanes = ram_rdata_i >> {offset_i, 3'b000};

	always_comb begin
		case (size_i)
			SZ_B: load_val = signed_i ? {{56{lanes[7]}}, lanes[7:0]}
			                          : {56'd0, lanes[7:0]};
			SZ_H: load_val = signed_i ? {{48{lanes[15]}}, lanes[15:0]}
			                          : {48'd0, lanes[15:0]};
			SZ_W: load_val = signed_i ? {{32{lanes[31]}}, lanes[31:0]}
			                          : {32'd0, lanes[31:0]};
			default: load_val = lanes;  // full doubleword, nothing to extend
		endcase
	end

	assign rf_we_o    = wen_i;
	assign rf_waddr_o = rd_i;
	assign rf_wdata_o = is_load_i ? load_val : alu_res_i;

endmodule

`default_nettype wire

/* hdl/regfile.sv */
`default_nettype none

`include "core_defines.svh"

module regfile import rv_core_pkg::*; (
	input  wire       clk,
	input  wire       rst_n,
	input  wire       we_i,
	input  reg_addr_t waddr_i,
	input  xlen_t     wdata_i,
	input  reg_addr_t dbg_raddr_i,
	output xlen_t     dbg_rdata_o
);

	localparam int NUM_REGS = 1 << `REG_ADDR_WIDTH;

	xlen_t regs [NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we_i && (waddr_i != '0)) begin  // x0 stays zero
			regs[waddr_i] <= wdata_i;
		end
	end

	// debug port, no read latency
	assign dbg_rdata_o = regs[dbg_raddr_i];

endmodule

`default_nettype wire

/* hdl/mem_wb_slice.sv */
`default_nettype none

module mem_wb_slice import rv_core_pkg::*, dmem_bus_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        ex_valid_i,
	input  xlen_t      ex_pc_i,
	input  xlen_t      ex_alu_res_i,
	input  reg_addr_t  ex_rd_i,
	input  wire        ex_reg_wen_i,
	input  mem_op_e    ex_mem_op_i,
	input  mem_size_e  ex_mem_size_i,
	input  wire        ex_mem_signed_i,
	input  xlen_t      ex_store_data_i,
	input  wire        ex_ebreak_i,
	output logic       ex_stall_o,
	input  wire        host_req_i,
	input  wire        host_we_i,
	input  dmem_addr_t host_addr_i,
	input  byte_mask_t host_wmask_i,
	input  xlen_t      host_wdata_i,
	output logic       host_gnt_o,
	output xlen_t      host_rdata_o,
	input  reg_addr_t  dbg_raddr_i,
	output xlen_t      dbg_rdata_o,
	output logic       ebreak_o,
	output xlen_t      wb_pc_o
);

	// core side of the RAM bus
	logic       core_req, core_we, core_gnt;
	dmem_addr_t core_addr;
	byte_mask_t core_wmask;
	xlen_t      core_wdata;

	// shared RAM port
	logic       ram_en, ram_we;
	dmem_addr_t ram_addr;
	byte_mask_t ram_wmask;
	xlen_t      ram_wdata, ram_rdata;

	// MEM stage outputs
	logic       m_wen, m_is_load, m_signed, m_ebreak;
	reg_addr_t  m_rd;
	xlen_t      m_alu_res, m_pc;
	mem_size_e  m_size;
	logic [2:0] m_offset;

	// WB stage inputs
	logic       w_wen, w_is_load, w_signed;
	reg_addr_t  w_rd;
	xlen_t      w_alu_res;
	mem_size_e  w_size;
	logic [2:0] w_offset;

	// register file write
	logic       rf_we;
	reg_addr_t  rf_waddr;
	xlen_t      rf_wdata;

	mem_stage u_mem_stage (
		.clk, .rst_n,
		.ex_valid_i, .ex_pc_i, .ex_alu_res_i, .ex_rd_i, .ex_reg_wen_i,
		.ex_mem_op_i, .ex_mem_size_i, .ex_mem_signed_i, .ex_store_data_i, .ex_ebreak_i,
		.core_gnt_i(core_gnt), .core_req_o(core_req), .core_we_o(core_we),
		.core_addr_o(core_addr), .core_wmask_o(core_wmask), .core_wdata_o(core_wdata),
		.stall_o(ex_stall_o),
		.wen_o(m_wen), .rd_o(m_rd), .alu_res_o(m_alu_res), .is_load_o(m_is_load),
		.size_o(m_size), .signed_o(m_signed), .offset_o(m_offset),
		.ebreak_o(m_ebreak), .pc_o(m_pc)
	);

	dmem_arbiter u_arbiter (
		.clk, .rst_n,
		.core_req_i(core_req), .core_we_i(core_we), .core_addr_i(core_addr),
		.core_wmask_i(core_wmask), .core_wdata_i(core_wdata),
		.host_req_i, .host_we_i, .host_addr_i, .host_wmask_i, .host_wdata_i,
		.core_gnt_o(core_gnt), .host_gnt_o,
		.ram_en_o(ram_en), .ram_we_o(ram_we), .ram_addr_o(ram_addr),
		.ram_wmask_o(ram_wmask), .ram_wdata_o(ram_wdata)
	);

	dmem_ram u_ram (
		.clk, .en_i(ram_en), .we_i(ram_we), .addr_i(ram_addr),
		.wmask_i(ram_wmask), .wdata_i(ram_wdata), .rdata_o(ram_rdata)
	);

	assign host_rdata_o = ram_rdata;  // read data goes to both requesters

	mem_wb_regs u_mem_wb_regs (
		.clk, .rst_n, .stall_i(ex_stall_o),
		.wen_i(m_wen), .rd_i(m_rd), .alu_res_i(m_alu_res), .is_load_i(m_is_load),
		.size_i(m_size), .signed_i(m_signed), .offset_i(m_offset),
		.ebreak_i(m_ebreak), .pc_i(m_pc),
		.wen_o(w_wen), .rd_o(w_rd), .alu_res_o(w_alu_res), .is_load_o(w_is_load),
		.size_o(w_size), .signed_o(w_signed), .offset_o(w_offset),
		.ebreak_o(ebreak_o), .pc_o(wb_pc_o)
	);

	wb_stage u_wb_stage (
		.wen_i(w_wen), .rd_i(w_rd), .alu_res_i(w_alu_res), .is_load_i(w_is_load),
		.size_i(w_size), .signed_i(w_signed), .offset_i(w_offset),
		.ram_rdata_i(ram_rdata),
		.rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata)
	);

	regfile u_regfile (
		.clk, .rst_n,
		.we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
		.dbg_raddr_i, .dbg_rdata_o
	);

endmodule

`default_nettype wire

/* verification/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD     = 20,
	parameter int RST_CYCLES = 4
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	// released on a rising edge so the DUT sees one clean reset edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

/* verification/mem_wb_tb.sv */
`default_nettype none

`include "core_defines.svh"

module mem_wb_tb import rv_core_pkg::*, dmem_bus_pkg::*; ();

	localparam int N_ALU  = 40;
	localparam int N_FILL = 16;  // doublewords touched by the memory tests
	localparam int N_LS   = 48;
	localparam int N_CONF = 32;
	localparam int N_EBRK = 4;
	// core instructions, host accesses and the two register sweeps
	localparam int N_OPS = 32 + 1 + N_ALU + 4 * N_FILL + 2 * N_LS + 2 * N_CONF + 2 * N_EBRK + 32;
	localparam int MAX_CYCLES = 2 * N_OPS + 200;

	logic       clk, rst_n;
	logic       ex_valid_i, ex_reg_wen_i, ex_mem_signed_i, ex_ebreak_i;
	xlen_t      ex_pc_i, ex_alu_res_i, ex_store_data_i;
	reg_addr_t  ex_rd_i;
	mem_op_e    ex_mem_op_i;
	mem_size_e  ex_mem_size_i;
	logic       host_req_i, host_we_i;
	dmem_addr_t host_addr_i;
	byte_mask_t host_wmask_i;
	xlen_t      host_wdata_i;
	reg_addr_t  dbg_raddr_i;
	logic       ex_stall_o, host_gnt_o, ebreak_o;
	xlen_t      host_rdata_o, dbg_rdata_o, wb_pc_o;

	logic [7:0]  ram_model [0:8191];  // one entry per RAM byte
	xlen_t       reg_model [32];
	int          rb_due_q[$], eb_due_q[$], hr_due_q[$];
	reg_addr_t   rb_rd_q[$];
	xlen_t       rb_exp_q[$], eb_pc_q[$], hr_exp_q[$];
	logic        h_we [N_CONF];
	dmem_addr_t  h_dw [N_CONF];
	byte_mask_t  h_mask [N_CONF];
	xlen_t       h_data [N_CONF];
	logic [31:0] lfsr = 32'hd1ff7a47;
	int          cyc, errors, n_checks, n_conflicts;
	logic        last_host;
	xlen_t       next_pc;

	tb_clk_gen #(.PERIOD(20), .RST_CYCLES(4)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

	mem_wb_slice uut (.*);

	// galois lfsr, x^32 + x^22 + x^2 + x + 1
	function automatic xlen_t rand_bits(input int n);
		xlen_t r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	// expected load value from the byte model
	function automatic xlen_t load_ref(input int dw, input int off, input mem_size_e size,
	                                   input logic sgn);
		xlen_t v;
		int    nb;
		v  = '0;
		nb = 1 << size;
		for (int k = 0; k < nb; k++)
			v[k*8 +: 8] = ram_model[dw*8 + off + k];
		if (sgn && nb < 8 && v[nb*8-1])
			v = v | ({64{1'b1}} << (nb * 8));  // sign fill above the loaded bytes
		return v;
	endfunction

	task automatic check(input string name, input xlen_t exp, input xlen_t act);
		n_checks++;
		if (exp !== act) begin
			errors++;
			$display("Error %s at cycle %0d: expected %h, actual %h", name, cyc, exp, act);
		end
	endtask

	task automatic expect_reg(input reg_addr_t rd, input xlen_t val, input int due);
		rb_due_q.push_back(due);
		rb_rd_q.push_back(rd);
		rb_exp_q.push_back(val);
	endtask

	// drive one EX slot and hold it until the stage takes it
	task automatic issue(input mem_op_e op, input mem_size_e size, input logic sgn,
	                     input xlen_t alu, input reg_addr_t rd, input logic wen,
	                     input xlen_t sdata, input logic ebrk);
		logic  taken;
		xlen_t val;
		int    dw;
		int    off;
		@(posedge clk);
		ex_valid_i      <= 1'b1;
		ex_pc_i         <= next_pc;
		ex_alu_res_i    <= alu;
		ex_rd_i         <= rd;
		ex_reg_wen_i    <= wen;
		ex_mem_op_i     <= op;
		ex_mem_size_i   <= size;
		ex_mem_signed_i <= sgn;
		ex_store_data_i <= sdata;
		ex_ebreak_i     <= ebrk;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = !ex_stall_o;
		end
		dw  = alu[`DMEM_DEPTH_LOG2+2:3];
		off = alu[2:0];
		val = alu;
		if (op == MEM_STORE) begin
			for (int k = 0; k < (1 << size); k++)
				ram_model[dw*8 + off + k] = sdata[k*8 +: 8];
		end
		if (op == MEM_LOAD)
			val = load_ref(dw, off, size, sgn);
		if (wen) begin
			if (rd != 0)
				reg_model[rd] = val;
			expect_reg(rd, reg_model[rd], cyc + 2);  // visible two cycles later
		end
		if (ebrk) begin
			eb_due_q.push_back(cyc + 1);
			eb_pc_q.push_back(next_pc);
		end
		next_pc = next_pc + 4;
	endtask

	task automatic core_idle();
		@(posedge clk);
		ex_valid_i  <= 1'b0;
		ex_mem_op_i <= MEM_NONE;
	endtask

	task automatic host_op(input logic we, input dmem_addr_t dw, input byte_mask_t mask,
	                       input xlen_t data);
		logic taken;
		@(posedge clk);
		host_req_i   <= 1'b1;
		host_we_i    <= we;
		host_addr_i  <= dw;
		host_wmask_i <= mask;
		host_wdata_i <= data;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = host_gnt_o;
		end
		if (we) begin
			for (int k = 0; k < 8; k++)
				if (mask[k])
					ram_model[dw*8 + k] = data[k*8 +: 8];
		end else begin
			hr_due_q.push_back(cyc + 1);
			hr_exp_q.push_back(load_ref(dw, 0, SZ_D, 1'b0));
		end
	endtask

	task automatic host_idle();
		@(posedge clk);
		host_req_i <= 1'b0;
	endtask

	// store at a random aligned spot, then load back from the same doubleword
	task automatic mem_pair(input mem_size_e st_size, input mem_size_e ld_size, input logic sgn);
		xlen_t      base;
		xlen_t      data;
		logic [2:0] off;
		reg_addr_t  rd;
		base = rand_bits(4) << 3;
		off  = rand_bits(3);
		off  = off & (3'b111 << st_size);
		data = rand_bits(64);
		issue(MEM_STORE, st_size, 1'b0, base | off, '0, 1'b0, data, 1'b0);
		off  = rand_bits(3);
		off  = off & (3'b111 << ld_size);
		rd   = rand_bits(5);
		issue(MEM_LOAD, ld_size, sgn, base | off, rd, 1'b1, '0, 1'b0);
	endtask

	// read every register back and wait for the results
	task automatic sweep_regs();
		@(negedge clk);
		for (int r = 0; r < 32; r++)
			expect_reg(reg_addr_t'(r), reg_model[r], cyc + 2 + r);
		while (rb_due_q.size() != 0)
			@(negedge clk);
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	always @(posedge clk) begin
		if (cyc >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles: %0d checks, %0d errors", cyc, n_checks, errors);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// debug address goes out one edge before the sample
	always @(posedge clk) begin
		if (rst_n && rb_due_q.size() > 0 && rb_due_q[0] == cyc + 1)
			dbg_raddr_i <= rb_rd_q[0];
	end

	always @(negedge clk) begin : compare
		logic core_want;
		logic core_win;
		logic host_win;
		logic eb_exp;
		if (rst_n) begin
			if (cyc == 0)
				check("reset_pc", `RESET_PC, wb_pc_o);
			core_want = ex_valid_i && (ex_mem_op_i != MEM_NONE);
			if (core_want && host_req_i) begin
				n_conflicts++;
				core_win = last_host;  // round robin
			end else begin
				core_win = core_want;
			end
			host_win = host_req_i && !core_win;
			check("host_gnt", host_win, host_gnt_o);
			check("ex_stall", core_want && !core_win, ex_stall_o);
			if (core_win)
				last_host = 1'b0;
			else if (host_win)
				last_host = 1'b1;

			eb_exp = eb_due_q.size() > 0 && eb_due_q[0] == cyc;
			check("ebreak", eb_exp, ebreak_o);
			if (eb_exp) begin
				check("ebreak_pc", eb_pc_q[0], wb_pc_o);
				eb_due_q.delete(0);
				eb_pc_q.delete(0);
			end

			if (rb_due_q.size() > 0 && rb_due_q[0] == cyc) begin
				check($sformatf("reg_x%0d", rb_rd_q[0]), rb_exp_q[0], dbg_rdata_o);
				rb_due_q.delete(0);
				rb_rd_q.delete(0);
				rb_exp_q.delete(0);
			end

			if (hr_due_q.size() > 0 && hr_due_q[0] == cyc) begin
				check("host_rdata", hr_exp_q[0], host_rdata_o);
				hr_due_q.delete(0);
				hr_exp_q.delete(0);
			end
		end
	end

	initial begin : stimulus
		xlen_t      alu;
		reg_addr_t  rd;
		logic       wen;
		mem_size_e  size;
		logic [2:0] off;
		ex_valid_i      = 1'b0;
		ex_pc_i         = '0;
		ex_alu_res_i    = '0;
		ex_rd_i         = '0;
		ex_reg_wen_i    = 1'b0;
		ex_mem_op_i     = MEM_NONE;
		ex_mem_size_i   = SZ_B;
		ex_mem_signed_i = 1'b0;
		ex_store_data_i = '0;
		ex_ebreak_i     = 1'b0;
		host_req_i      = 1'b0;
		host_we_i       = 1'b0;
		host_addr_i     = '0;
		host_wmask_i    = '0;
		host_wdata_i    = '0;
		dbg_raddr_i     = '0;
		last_host       = 1'b1;  // core takes the first conflict
		next_pc         = `RESET_PC;
		for (int i = 0; i < 32; i++)
			reg_model[i] = '0;
		wait (rst_n);

		sweep_regs();
		alu = rand_bits(64);
		issue(MEM_NONE, SZ_D, 1'b0, alu, '0, 1'b1, '0, 1'b0);  // x0 stays zero

		for (int i = 0; i < N_ALU; i++) begin
			alu = rand_bits(64);
			rd  = rand_bits(5);
			wen = rand_bits(3) != 0;
			issue(MEM_NONE, SZ_D, 1'b0, alu, rd, wen, '0, 1'b0);
		end
		core_idle();

		// host fills the test area, core reads it back
		for (int i = 0; i < N_FILL; i++)
			host_op(1'b1, dmem_addr_t'(i), 8'hff, rand_bits(64));
		host_idle();
		for (int i = 0; i < N_FILL; i++) begin
			rd = rand_bits(5);
			issue(MEM_LOAD, SZ_D, 1'b0, xlen_t'(i) << 3, rd, 1'b1, '0, 1'b0);
		end

		for (int i = 0; i < N_LS; i++)
			mem_pair(mem_size_e'(i % 4), mem_size_e'((i / 4) % 4), (i / 16) % 2);

		// core stores, host reads
		for (int i = 0; i < N_FILL; i++) begin
			size = mem_size_e'(rand_bits(2));
			off  = rand_bits(3);
			off  = off & (3'b111 << size);
			alu  = rand_bits(64);
			issue(MEM_STORE, size, 1'b0, (xlen_t'(i) << 3) | off, '0, 1'b0, alu, 1'b0);
		end
		core_idle();
		for (int i = 0; i < N_FILL; i++)
			host_op(1'b0, dmem_addr_t'(i), '0, '0);
		host_idle();

		// both sides hammer the RAM at once
		for (int i = 0; i < N_CONF; i++) begin
			h_we[i]   = i % 2;
			h_dw[i]   = rand_bits(4);
			h_mask[i] = rand_bits(8);
			h_data[i] = rand_bits(64);
		end
		fork
			begin
				for (int i = 0; i < N_CONF; i++)
					host_op(h_we[i], h_dw[i], h_mask[i], h_data[i]);
				host_idle();
			end
			begin
				for (int i = 0; i < N_CONF / 2; i++)
					mem_pair(mem_size_e'(i % 4), mem_size_e'((i / 4) % 4), i % 2);
				core_idle();
			end
		join

		for (int i = 0; i < N_EBRK; i++) begin
			next_pc = rand_bits(64) & ~64'h3;
			alu     = rand_bits(64);
			rd      = rand_bits(5);
			issue(MEM_NONE, SZ_D, 1'b0, alu, rd, 1'b1, '0, 1'b1);
			alu = rand_bits(64);
			issue(MEM_NONE, SZ_D, 1'b0, alu, rd, 1'b0, '0, 1'b0);
		end
		core_idle();

		sweep_regs();  // catches any stray write by a bubble
		repeat (3) @(negedge clk);
		if (n_conflicts == 0) begin
			errors++;
			$display("No cycle had core and host requesting the RAM together");
		end
		if (eb_due_q.size() != 0 || hr_due_q.size() != 0 || rb_due_q.size() != 0) begin
			errors++;
			$display("Some expected results were never compared");
		end
		$display("checks: %0d, errors: %0d", n_checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/dmem_bus_pkg.sv
hdl/dmem_arbiter.sv
hdl/dmem_ram.sv
hdl/mem_stage.sv
hdl/mem_wb_regs.sv
hdl/wb_stage.sv
hdl/regfile.sv
hdl/mem_wb_slice.sv
verification/tb_clk_gen.sv
verification/mem_wb_tb.sv

/* Bender.yml */
package:
  name: mem_wb_slice

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_core_pkg.sv
      - hdl/dmem_bus_pkg.sv
      - hdl/dmem_arbiter.sv
      - hdl/dmem_ram.sv
      - hdl/mem_stage.sv
      - hdl/mem_wb_regs.sv
      - hdl/wb_stage.sv
      - hdl/regfile.sv
      - hdl/mem_wb_slice.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/tb_clk_gen.sv
      - verification/mem_wb_tb.sv
